/* cp0_params.svh */
`ifndef CP0_PARAMS_SVH
`define CP0_PARAMS_SVH

// Register addresses, {rd, sel}
`define CP0_INDEX       8'h00
`define CP0_ENTRYLO0    8'h10
`define CP0_ENTRYLO1    8'h18
`define CP0_BADVADDR    8'h40
`define CP0_COUNT       8'h48
`define CP0_ENTRYHI     8'h50
`define CP0_COMPARE     8'h58
`define CP0_STATUS      8'h60
`define CP0_CAUSE       8'h68
`define CP0_EPC         8'h70

// Exception codes in Cause.ExcCode
`define EXC_INT         5'h00
`define EXC_ADEL        5'h04   // Address error on load or fetch
`define EXC_ADES        5'h05   // Address error on store

// TLB geometry, 8 or 32 entries also work
`define TLB_ENTRIES     16
`define TLB_IDX_W       4

// Timer
`define COMPARE_RESET   32'h0001_0000

`endif

/* cp0_pkg.sv */
`include "cp0_params.svh"

package cp0_pkg;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_MTC0,
        OP_MFC0,
        OP_ERET,
        OP_TLBR,
        OP_TLBWI,
        OP_TLBP
    } cp0_op_e;

    // Writeback event, one cycle wide
    typedef struct packed {
        logic        valid;
        cp0_op_e     op;
        logic        ex;           // Exception, op is ignored
        logic [4:0]  exc_code;
        logic        bd;           // Faulting instruction sits in a delay slot
        logic [4:0]  rd;
        logic [2:0]  sel;
        logic [31:0] wdata;
        logic [31:0] pc;
        logic [31:0] bad_addr;
    } cp0_wb_t;

    typedef struct packed {
        logic [5:0]  zero;
        logic [19:0] pfn;
        logic [2:0]  c;            // Cache attribute, stored only
        logic        d;
        logic        v;
        logic        g;
    } entrylo_f_t;

    // EntryLo word, raw for mtc0/mfc0 and split into fields for the TLB
    typedef union packed {
        logic [31:0] raw;
        entrylo_f_t  f;
    } entrylo_u;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;            // AND of both lo g bits
        logic [19:0] pfn0;
        logic [2:0]  c0;
        logic        d0;
        logic        v0;
        logic [19:0] pfn1;
        logic [2:0]  c1;
        logic        d1;
        logic        v1;
    } tlb_entry_t;

    typedef struct packed {
        logic                  we;            // tlbwi
        logic [`TLB_IDX_W-1:0] idx;
        tlb_entry_t            entry;
        logic [18:0]           probe_vpn2;
        logic [7:0]            probe_asid;
    } tlb_cmd_t;

    typedef struct packed {
        logic                  probe_hit;
        logic [`TLB_IDX_W-1:0] probe_idx;
        tlb_entry_t            rd_entry;      // Entry at cmd.idx
    } tlb_rsp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] vaddr;
    } xlate_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] paddr;
        logic        miss;
        logic        invalid;
        logic        dirty;
    } xlate_rsp_t;

    // Status towards the pipeline
    typedef struct packed {
        logic [31:0] epc;
        logic        eret_flush;
        logic        int_req;
        logic        exl;
        logic [7:0]  asid;
    } cp0_ctl_t;

endpackage

/* cp0_regs.sv */
`include "cp0_params.svh"

module cp0_regs (
    input  logic              clk,
    input  logic              reset,
    input  cp0_pkg::cp0_wb_t  wb,
    input  logic [5:0]        ext_int,
    output logic [31:0]       rdata,
    output cp0_pkg::cp0_ctl_t ctl,
    output cp0_pkg::tlb_cmd_t tlb_cmd,
    input  cp0_pkg::tlb_rsp_t tlb_rsp
);
    import cp0_pkg::*;

    logic [7:0]            addr;
    logic                  ex_evt;
    logic                  eret_evt;
    logic                  mtc0_we;
    logic                  tlbr_evt;
    logic                  tlbwi_evt;
    logic                  tlbp_evt;

    logic                  index_p;
    logic [`TLB_IDX_W-1:0] index_idx;
    logic [18:0]           entryhi_vpn2;
    logic [7:0]            entryhi_asid;
    entrylo_u              entrylo0;
    entrylo_u              entrylo1;
    entrylo_u              rd_lo0;
    entrylo_u              rd_lo1;
    logic [31:0]           badvaddr;
    logic                  tick;
    logic [31:0]           count;
    logic [31:0]           compare;
    logic                  status_ie;
    logic                  status_exl;
    logic [7:0]            status_im;
    logic                  cause_bd;
    logic                  cause_ti;
    logic [4:0]            cause_exc;
    logic [1:0]            cause_ip_sw;
    logic [5:0]            ext_int_q;
    logic [7:0]            cause_ip;
    logic [31:0]           epc;

    assign addr      = {wb.rd, wb.sel};
    assign ex_evt    = wb.valid && wb.ex;
    assign eret_evt  = wb.valid && !wb.ex && (wb.op == OP_ERET);
    assign mtc0_we   = wb.valid && !wb.ex && (wb.op == OP_MTC0);
    assign tlbr_evt  = wb.valid && !wb.ex && (wb.op == OP_TLBR);
    assign tlbwi_evt = wb.valid && !wb.ex && (wb.op == OP_TLBWI);
    assign tlbp_evt  = wb.valid && !wb.ex && (wb.op == OP_TLBP);

    always_ff @(posedge clk) begin
        if (reset) begin
            status_exl <= 1'b0;
            status_ie  <= 1'b0;
            status_im  <= 8'h00;
        end else if (ex_evt) begin
            status_exl <= 1'b1;
        end else if (eret_evt) begin
            status_exl <= 1'b0;
        end else if (mtc0_we && addr == `CP0_STATUS) begin
            status_im  <= wb.wdata[15:8];
            status_exl <= wb.wdata[1];
            status_ie  <= wb.wdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd    <= 1'b0;
            cause_exc   <= 5'd0;
            cause_ip_sw <= 2'b00;
        end else if (ex_evt) begin
            cause_bd  <= wb.bd;
            cause_exc <= wb.exc_code;
        end else if (mtc0_we && addr == `CP0_CAUSE) begin
            cause_ip_sw <= wb.wdata[9:8];                // Software interrupts only
        end
    end

    // Nested exceptions keep the first EPC
    always_ff @(posedge clk) begin
        if (ex_evt && !status_exl) begin
            epc <= wb.bd ? wb.pc - 32'd4 : wb.pc;        // Point back at the branch
        end else if (mtc0_we && addr == `CP0_EPC) begin
            epc <= wb.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_evt && (wb.exc_code == `EXC_ADEL || wb.exc_code == `EXC_ADES)) begin
            badvaddr <= wb.bad_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tick  <= 1'b0;
            count <= 32'd0;
        end else begin
            tick <= ~tick;                               // Count runs at half rate
            if (mtc0_we && addr == `CP0_COUNT) begin
                count <= wb.wdata;
            end else if (tick) begin
                count <= count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= `COMPARE_RESET;
        end else if (mtc0_we && addr == `CP0_COMPARE) begin
            compare <= wb.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_ti <= 1'b0;
        end else if (mtc0_we && addr == `CP0_COMPARE) begin
            cause_ti <= 1'b0;                            // Writing Compare acks the timer
        end else if (count == compare) begin
            cause_ti <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ext_int_q <= 6'd0;
        end else begin
            ext_int_q <= ext_int;
        end
    end

    assign cause_ip = {ext_int_q[5] | cause_ti, ext_int_q[4:0], cause_ip_sw};

    always_ff @(posedge clk) begin
        if (reset) begin
            entryhi_vpn2 <= 19'd0;
            entryhi_asid <= 8'd0;
        end else if (tlbr_evt) begin
            entryhi_vpn2 <= tlb_rsp.rd_entry.vpn2;
            entryhi_asid <= tlb_rsp.rd_entry.asid;
        end else if (mtc0_we && addr == `CP0_ENTRYHI) begin
            entryhi_vpn2 <= wb.wdata[31:13];
            entryhi_asid <= wb.wdata[7:0];
        end
    end

    always_comb begin
        rd_lo0.f.zero = 6'd0;
        rd_lo0.f.pfn  = tlb_rsp.rd_entry.pfn0;
        rd_lo0.f.c    = tlb_rsp.rd_entry.c0;
        rd_lo0.f.d    = tlb_rsp.rd_entry.d0;
        rd_lo0.f.v    = tlb_rsp.rd_entry.v0;
        rd_lo0.f.g    = tlb_rsp.rd_entry.g;
        rd_lo1.f.zero = 6'd0;
        rd_lo1.f.pfn  = tlb_rsp.rd_entry.pfn1;
        rd_lo1.f.c    = tlb_rsp.rd_entry.c1;
        rd_lo1.f.d    = tlb_rsp.rd_entry.d1;
        rd_lo1.f.v    = tlb_rsp.rd_entry.v1;
        rd_lo1.f.g    = tlb_rsp.rd_entry.g;
    end

    always_ff @(posedge clk) begin
        if (tlbr_evt) begin
            entrylo0 <= rd_lo0;
            entrylo1 <= rd_lo1;
        end else if (mtc0_we && addr == `CP0_ENTRYLO0) begin
            entrylo0.raw <= {6'd0, wb.wdata[25:0]};
        end else if (mtc0_we && addr == `CP0_ENTRYLO1) begin
            entrylo1.raw <= {6'd0, wb.wdata[25:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            index_p   <= 1'b0;
            index_idx <= '0;
        end else if (tlbp_evt) begin
            index_p <= !tlb_rsp.probe_hit;               // P flags a probe miss
            if (tlb_rsp.probe_hit) begin
                index_idx <= tlb_rsp.probe_idx;
            end
        end else if (mtc0_we && addr == `CP0_INDEX) begin
            index_idx <= wb.wdata[`TLB_IDX_W-1:0];
        end
    end

    always_comb begin
        tlb_cmd.we          = tlbwi_evt;
        tlb_cmd.idx         = index_idx;
        tlb_cmd.entry.vpn2  = entryhi_vpn2;
        tlb_cmd.entry.asid  = entryhi_asid;
        tlb_cmd.entry.g     = entrylo0.f.g & entrylo1.f.g;
        tlb_cmd.entry.pfn0  = entrylo0.f.pfn;
        tlb_cmd.entry.c0    = entrylo0.f.c;
        tlb_cmd.entry.d0    = entrylo0.f.d;
        tlb_cmd.entry.v0    = entrylo0.f.v;
        tlb_cmd.entry.pfn1  = entrylo1.f.pfn;
        tlb_cmd.entry.c1    = entrylo1.f.c;
        tlb_cmd.entry.d1    = entrylo1.f.d;
        tlb_cmd.entry.v1    = entrylo1.f.v;
        tlb_cmd.probe_vpn2  = entryhi_vpn2;
        tlb_cmd.probe_asid  = entryhi_asid;
    end

    // mfc0 read mux, Bev is hardwired
    always_comb begin
        case (addr)
            `CP0_INDEX:    rdata = {index_p, {(31 - `TLB_IDX_W){1'b0}}, index_idx};
            `CP0_ENTRYLO0: rdata = entrylo0.raw;
            `CP0_ENTRYLO1: rdata = entrylo1.raw;
            `CP0_BADVADDR: rdata = badvaddr;
            `CP0_COUNT:    rdata = count;
            `CP0_ENTRYHI:  rdata = {entryhi_vpn2, 5'd0, entryhi_asid};
            `CP0_COMPARE:  rdata = compare;
            `CP0_STATUS:   rdata = {9'd0, 1'b1, 6'd0, status_im, 6'd0, status_exl, status_ie};
            `CP0_CAUSE:    rdata = {cause_bd, cause_ti, 14'd0, cause_ip, 1'b0, cause_exc, 2'b00};
            `CP0_EPC:      rdata = epc;
            default:       rdata = 32'd0;
        endcase
    end

    assign ctl.epc        = epc;
    assign ctl.eret_flush = eret_evt;
    assign ctl.int_req    = status_ie && !status_exl && |(cause_ip & status_im);
    assign ctl.exl        = status_exl;
    assign ctl.asid       = entryhi_asid;

    // An excepting event never carries an eret
    assert property (@(posedge clk) disable iff (reset)
        wb.valid && wb.ex |-> wb.op != OP_ERET)
        else $error("cp0_regs: exception and eret in the same cycle");

    // eret only from inside a handler
    assert property (@(posedge clk) disable iff (reset)
        ctl.eret_flush |-> status_exl)
        else $error("cp0_regs: eret with EXL clear");

endmodule

/* tlb_array.sv */
`include "cp0_params.svh"

module tlb_array (
    input  logic                clk,
    input  logic                reset,
    input  cp0_pkg::tlb_cmd_t   cmd,
    output cp0_pkg::tlb_rsp_t   rsp,
    input  cp0_pkg::xlate_req_t xreq,
    output cp0_pkg::xlate_rsp_t xrsp,
    input  logic [7:0]          asid
);
    import cp0_pkg::*;

    tlb_entry_t              mem [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] loaded;
    logic [`TLB_ENTRIES-1:0] probe_hits;
    logic [`TLB_ENTRIES-1:0] xlate_hits;
    tlb_entry_t              xlate_entry;
    logic                    odd;
    logic [19:0]             page_pfn;
    logic                    page_v;
    logic                    page_d;

    // One bit per entry, global entries ignore the ASID
    function automatic logic [`TLB_ENTRIES-1:0] match_vec(
        input logic [18:0] vpn2,
        input logic [7:0]  id
    );
        logic [`TLB_ENTRIES-1:0] hits;
        hits = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            hits[i] = (mem[i].vpn2 == vpn2) && (mem[i].g || mem[i].asid == id);
        end
        return hits;
    endfunction

    // OR encoder, exact for a one-hot input
    function automatic logic [`TLB_IDX_W-1:0] encode(
        input logic [`TLB_ENTRIES-1:0] hits
    );
        logic [`TLB_IDX_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (hits[i]) begin
                idx = idx | i[`TLB_IDX_W-1:0];
            end
        end
        return idx;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                mem[i].v0 <= 1'b0;
                mem[i].v1 <= 1'b0;
                mem[i].g  <= 1'b0;
            end
        end else if (cmd.we) begin
            mem[cmd.idx] <= cmd.entry;                   // tlbwi
        end
    end

    // Entries written by tlbwi since reset
    always_ff @(posedge clk) begin
        if (reset) begin
            loaded <= '0;
        end else if (cmd.we) begin
            loaded[cmd.idx] <= 1'b1;
        end
    end

    // Probe search on EntryHi
    always_comb begin
        probe_hits    = match_vec(cmd.probe_vpn2, cmd.probe_asid);
        rsp.probe_hit = |probe_hits;
        rsp.probe_idx = encode(probe_hits);
        rsp.rd_entry  = mem[cmd.idx];                    // tlbr read port
    end

    // Translation search on the request address
    always_comb begin
        xlate_hits  = match_vec(xreq.vaddr[31:13], asid);
        xlate_entry = mem[encode(xlate_hits)];
        odd         = xreq.vaddr[12];                    // Odd page of the pair
        page_pfn    = odd ? xlate_entry.pfn1 : xlate_entry.pfn0;
        page_v      = odd ? xlate_entry.v1 : xlate_entry.v0;
        page_d      = odd ? xlate_entry.d1 : xlate_entry.d0;
    end

    always_ff @(posedge clk) begin
        xrsp.paddr   <= {page_pfn, xreq.vaddr[11:0]};
        xrsp.miss    <= ~|xlate_hits;
        xrsp.invalid <= (|xlate_hits) && !page_v;
        xrsp.dirty   <= page_d;
        if (reset) begin
            xrsp.valid <= 1'b0;
        end else begin
            xrsp.valid <= xreq.valid;
        end
    end

    // Duplicate entries are a software error
    assert property (@(posedge clk) disable iff (reset)
        $onehot0(probe_hits & loaded))
        else $error("tlb_array: several entries match the probe");

    assert property (@(posedge clk) disable iff (reset)
        xreq.valid |-> $onehot0(xlate_hits))
        else $error("tlb_array: several entries match the translation");

endmodule

/* cp0_tlb_top.sv */
module cp0_tlb_top (
    input  logic                clk,
    input  logic                reset,
    input  cp0_pkg::cp0_wb_t    wb,
    input  logic [5:0]          ext_int,
    output logic [31:0]         rdata,
    output cp0_pkg::cp0_ctl_t   ctl,
    input  cp0_pkg::xlate_req_t xreq,
    output cp0_pkg::xlate_rsp_t xrsp
);
    import cp0_pkg::*;

    tlb_cmd_t tlb_cmd;                                   // tlbwi, probe key, read index
    tlb_rsp_t tlb_rsp;                                   // Probe result and read entry

    cp0_regs cp0_regs_i (
        .clk     (clk),
        .reset   (reset),
        .wb      (wb),
        .ext_int (ext_int),
        .rdata   (rdata),
        .ctl     (ctl),
        .tlb_cmd (tlb_cmd),
        .tlb_rsp (tlb_rsp)
    );

    tlb_array tlb_array_i (
        .clk   (clk),
        .reset (reset),
        .cmd   (tlb_cmd),
        .rsp   (tlb_rsp),
        .xreq  (xreq),
        .xrsp  (xrsp),
        .asid  (ctl.asid)                                // Current ASID from EntryHi
    );

endmodule

/* tb_cp0_tlb.sv */
`include "cp0_params.svh"

module tb_cp0_tlb;
    import cp0_pkg::*;

    logic        clk;
    logic        reset;
    cp0_wb_t     wb;
    logic [5:0]  ext_int;
    logic [31:0] rdata;
    cp0_ctl_t    ctl;
    xlate_req_t  xreq;
    xlate_rsp_t  xrsp;

    integer      seed;
    logic [31:0] model [256];                            // Last value written per address
    logic [31:0] sh_hi [`TLB_ENTRIES];
    logic [31:0] sh_lo0 [`TLB_ENTRIES];
    logic [31:0] sh_lo1 [`TLB_ENTRIES];
    logic [7:0]  cur_asid;

    string       chk_name;
    logic [31:0] chk_exp;
    logic [31:0] chk_got;
    logic        chk_on;
    logic        xchk;
    logic        xchk_q;
    xlate_rsp_t  xexp;
    xlate_rsp_t  xexp_q;

    cp0_tlb_top dut_i (
        .clk     (clk),
        .reset   (reset),
        .wb      (wb),
        .ext_int (ext_int),
        .rdata   (rdata),
        .ctl     (ctl),
        .xreq    (xreq),
        .xrsp    (xrsp)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        xchk_q <= xchk;
        xexp_q <= xexp;
    end

    // Value checks staged by the tasks
    assert property (@(posedge clk) chk_on |-> chk_got == chk_exp)
        else begin
            $display("[FAIL] %s expected %h actual %h", chk_name, chk_exp, chk_got);
            $display("CHECKS FAILED");
            $fatal(1);
        end

    // Response one cycle after each request
    assert property (@(posedge clk) disable iff (reset)
        xchk_q |-> xrsp.valid && xrsp.miss == xexp_q.miss && xrsp.invalid == xexp_q.invalid
                   && (xexp_q.miss || (xrsp.paddr == xexp_q.paddr
                                       && xrsp.dirty == xexp_q.dirty)))
        else begin
            $display("[FAIL] translate expected %h actual %h (miss %b/%b, invalid %b/%b, %s)",
                     $sampled(xexp_q.paddr), $sampled(xrsp.paddr), $sampled(xexp_q.miss),
                     $sampled(xrsp.miss), $sampled(xexp_q.invalid), $sampled(xrsp.invalid),
                     $sformatf("dirty %b/%b", $sampled(xexp_q.dirty), $sampled(xrsp.dirty)));
            $display("CHECKS FAILED");
            $fatal(1);
        end

    task automatic expect_at_edge(string name, logic [31:0] exp, logic [31:0] act);
        chk_name = name;
        chk_exp  = exp;
        chk_got  = act;
        chk_on   = 1'b1;
        @(posedge clk);
        #1 chk_on = 1'b0;
    endtask

    task automatic issue(cp0_op_e op, logic [7:0] a, logic [31:0] d);
        wb       = '0;
        wb.valid = 1'b1;
        wb.op    = op;
        wb.rd    = a[7:3];
        wb.sel   = a[2:0];
        wb.wdata = d;
    endtask

    task automatic mtc0(logic [7:0] a, logic [31:0] d);
        issue(OP_MTC0, a, d);
        model[a] = d;
        @(posedge clk);
        #1 wb = '0;
    endtask

    task automatic mfc0(string name, logic [7:0] a, logic [31:0] exp, logic [31:0] mask);
        issue(OP_MFC0, a, 32'd0);
        #1 expect_at_edge(name, exp & mask, rdata & mask);
        wb = '0;
    endtask

    task automatic read_reg(logic [7:0] a, output logic [31:0] v);
        issue(OP_MFC0, a, 32'd0);
        #1 v = rdata;
        @(posedge clk);
        #1 wb = '0;
    endtask

    task automatic tlb_op(cp0_op_e op);
        issue(op, 8'd0, 32'd0);
        @(posedge clk);
        #1 wb = '0;
    endtask

    task automatic raise(logic [4:0] code, logic bd, logic [31:0] pc, logic [31:0] bad);
        wb          = '0;
        wb.valid    = 1'b1;
        wb.ex       = 1'b1;
        wb.exc_code = code;
        wb.bd       = bd;
        wb.pc       = pc;
        wb.bad_addr = bad;
        @(posedge clk);
        #1 wb = '0;
    endtask

    task automatic eret();
        issue(OP_ERET, 8'd0, 32'd0);
        #1 expect_at_edge("eret_flush", 32'd1, {31'd0, ctl.eret_flush});
        wb = '0;
    endtask

    task automatic idle(int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic write_entry(logic [3:0] idx, logic [31:0] hi, logic [31:0] lo0,
                               logic [31:0] lo1);
        mtc0(`CP0_INDEX, {28'd0, idx});
        mtc0(`CP0_ENTRYHI, hi);
        mtc0(`CP0_ENTRYLO0, lo0);
        mtc0(`CP0_ENTRYLO1, lo1);
        tlb_op(OP_TLBWI);
        sh_hi[idx]  = hi & 32'hffff_e0ff;
        sh_lo0[idx] = lo0 & 32'h03ff_ffff;
        sh_lo1[idx] = lo1 & 32'h03ff_ffff;
    endtask

    // Matching rule applied to the shadow TLB
    function automatic xlate_rsp_t expect_xlate(logic [31:0] va, logic [7:0] id);
        xlate_rsp_t  r;
        logic [31:0] lo;
        logic        g;
        r       = '0;
        r.valid = 1'b1;
        r.miss  = 1'b1;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            g = sh_lo0[i][0] & sh_lo1[i][0];
            if (sh_hi[i][31:13] == va[31:13] && (g || sh_hi[i][7:0] == id)) begin
                lo        = va[12] ? sh_lo1[i] : sh_lo0[i];
                r.miss    = 1'b0;
                r.paddr   = {lo[25:6], va[11:0]};
                r.invalid = !lo[1];
                r.dirty   = lo[2];
            end
        end
        return r;
    endfunction

    task automatic translate(logic [31:0] va);
        xreq.valid = 1'b1;
        xreq.vaddr = va;
        xexp       = expect_xlate(va, cur_asid);
        xchk       = 1'b1;
        @(posedge clk);
        #1;
    endtask

    initial begin
        logic [31:0]             v;
        logic [31:0]             c1;
        logic [31:0]             r;
        logic [31:0]             r2;
        logic [3:0]              idx;
        logic [3:0]              used [$];
        logic [`TLB_ENTRIES-1:0] taken;
        logic                    ti;

        seed = 32'hf87afad5;
        clk = 1'b0;
        reset = 1'b1;
        wb = '0;
        ext_int = 6'd0;
        xreq = '0;
        xexp = '0;
        xchk = 1'b0;
        chk_on = 1'b0;
        cur_asid = 8'd0;
        taken = '0;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        // Register round trip
        mtc0(`CP0_EPC, 32'hbfc0_0180);
        mfc0("epc", `CP0_EPC, model[`CP0_EPC], 32'hffff_ffff);
        mtc0(`CP0_COMPARE, 32'h1234_5678);
        mfc0("compare", `CP0_COMPARE, model[`CP0_COMPARE], 32'hffff_ffff);
        mtc0(`CP0_ENTRYHI, 32'hdead_beef);
        mfc0("entryhi", `CP0_ENTRYHI, model[`CP0_ENTRYHI] & 32'hffff_e0ff, 32'hffff_ffff);
        expect_at_edge("ctl_asid", {24'd0, model[`CP0_ENTRYHI][7:0]}, {24'd0, ctl.asid});
        mtc0(`CP0_ENTRYLO0, 32'hffff_fff7);
        mfc0("entrylo0", `CP0_ENTRYLO0, model[`CP0_ENTRYLO0] & 32'h03ff_ffff, 32'hffff_ffff);
        mtc0(`CP0_ENTRYLO1, 32'h5a5a_a5a5);
        mfc0("entrylo1", `CP0_ENTRYLO1, model[`CP0_ENTRYLO1] & 32'h03ff_ffff, 32'hffff_ffff);
        mtc0(`CP0_INDEX, 32'h0000_0005);
        mfc0("index", `CP0_INDEX, model[`CP0_INDEX], 32'h8000_000f);
        mtc0(`CP0_STATUS, 32'hffff_ab01);
        mfc0("status", `CP0_STATUS, (model[`CP0_STATUS] & 32'h0000_ff03) | 32'h0040_0000,
             32'hffff_ffff);
        mtc0(`CP0_CAUSE, 32'hffff_ffff);
        mfc0("cause", `CP0_CAUSE, model[`CP0_CAUSE] & 32'h0000_0300, 32'hffff_ffff);
        mtc0(`CP0_CAUSE, 32'd0);
        mtc0(`CP0_STATUS, 32'd0);

        // Exceptions and eret
        raise(`EXC_ADES, 1'b0, 32'h8000_1000, 32'h0000_1234);
        expect_at_edge("ctl_exl", 32'd1, {31'd0, ctl.exl});
        expect_at_edge("ctl_epc", 32'h8000_1000, ctl.epc);
        mfc0("epc_bd0", `CP0_EPC, 32'h8000_1000, 32'hffff_ffff);
        mfc0("cause_ades", `CP0_CAUSE, {1'b0, 24'd0, `EXC_ADES, 2'b00}, 32'h8000_007c);
        mfc0("badvaddr", `CP0_BADVADDR, 32'h0000_1234, 32'hffff_ffff);
        eret();
        mfc0("exl_clear", `CP0_STATUS, 32'd0, 32'h0000_0002);
        raise(`EXC_ADEL, 1'b1, 32'h8000_2000, 32'h0000_5678);
        mfc0("epc_bd1", `CP0_EPC, 32'h8000_1ffc, 32'hffff_ffff);
        mfc0("cause_bd", `CP0_CAUSE, {1'b1, 24'd0, `EXC_ADEL, 2'b00}, 32'h8000_007c);
        raise(`EXC_INT, 1'b0, 32'h8000_3000, 32'd0);
        mfc0("epc_nested", `CP0_EPC, 32'h8000_1ffc, 32'hffff_ffff);
        eret();
        mfc0("exl_clear2", `CP0_STATUS, 32'd0, 32'h0000_0002);

        // Timer
        read_reg(`CP0_COUNT, c1);
        idle(10);
        read_reg(`CP0_COUNT, v);
        expect_at_edge("count_rate", 32'd1, {31'd0, (v - c1 >= 32'd4) && (v - c1 <= 32'd7)});
        read_reg(`CP0_COUNT, c1);
        mtc0(`CP0_COMPARE, c1 + 32'd4);
        ti = 1'b0;
        for (int i = 0; i < 100 && !ti; i++) begin
            read_reg(`CP0_CAUSE, v);
            ti = v[30];
        end
        if (!ti) begin
            $display("Timer interrupt did not set within 100 cycles");
            $display("CHECKS FAILED");
            $fatal(1);
        end
        mfc0("ti_set", `CP0_CAUSE, 32'h4000_0000, 32'h4000_0000);
        mtc0(`CP0_COMPARE, 32'hffff_0000);
        mfc0("ti_clear", `CP0_CAUSE, 32'd0, 32'h4000_0000);

        // Interrupt request from ext_int[4] on IP6
        mtc0(`CP0_STATUS, 32'h0000_4001);
        ext_int = 6'b01_0000;
        idle(1);
        expect_at_edge("int_req_on", 32'd1, {31'd0, ctl.int_req});
        mtc0(`CP0_STATUS, 32'h0000_4003);
        expect_at_edge("int_req_exl", 32'd0, {31'd0, ctl.int_req});
        mtc0(`CP0_STATUS, 32'h0000_0001);
        expect_at_edge("int_req_masked", 32'd0, {31'd0, ctl.int_req});
        ext_int = 6'd0;
        mtc0(`CP0_STATUS, 32'd0);

        // TLB fill with distinct invalid entries, then random ones
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            write_entry(4'(i), {14'd0, 1'b0, 4'(i), 13'd0}, 32'd0, 32'd0);
        end
        r = $random(seed);
        cur_asid = r[7:0];
        for (int k = 0; k < 6; k++) begin
            r = $random(seed);
            r2 = $random(seed);
            idx = r[3:0];
            for (int t = 0; t < `TLB_ENTRIES && taken[idx]; t++) begin
                idx = idx + 4'd1;                        // Next free slot
            end
            taken[idx] = 1'b1;
            used.push_back(idx);
            write_entry(idx, {r[17:4], 1'b1, idx, 5'd0, cur_asid},
                        {6'd0, r2[19:0], 3'd2, r2[20], r2[21] | (k == 0), k == 0},
                        {6'd0, r[31:12], 3'd3, r2[22], k != 1, k == 0});
        end

        // tlbr restores what was written
        foreach (used[k]) begin
            idx = used[k];
            mtc0(`CP0_ENTRYHI, 32'h0000_0000);
            mtc0(`CP0_ENTRYLO0, 32'h0000_0000);
            mtc0(`CP0_ENTRYLO1, 32'h0000_0000);
            mtc0(`CP0_INDEX, {28'd0, idx});
            tlb_op(OP_TLBR);
            mfc0("tlbr_hi", `CP0_ENTRYHI, sh_hi[idx], 32'hffff_ffff);
            mfc0("tlbr_lo0", `CP0_ENTRYLO0,
                 {sh_lo0[idx][31:1], sh_lo0[idx][0] & sh_lo1[idx][0]}, 32'hffff_ffff);
            mfc0("tlbr_lo1", `CP0_ENTRYLO1,
                 {sh_lo1[idx][31:1], sh_lo0[idx][0] & sh_lo1[idx][0]}, 32'hffff_ffff);
        end

        // tlbp miss, hit, global hit under another ASID
        mtc0(`CP0_INDEX, 32'd3);
        mtc0(`CP0_ENTRYHI, {14'h3fff, 1'b0, 4'hf, 5'd0, cur_asid});
        tlb_op(OP_TLBP);
        mfc0("tlbp_miss", `CP0_INDEX, 32'h8000_0003, 32'h8000_000f);
        idx = used[used.size() - 1];
        mtc0(`CP0_INDEX, {28'd0, ~idx});
        mtc0(`CP0_ENTRYHI, sh_hi[idx]);
        tlb_op(OP_TLBP);
        mfc0("tlbp_hit", `CP0_INDEX, {28'd0, idx}, 32'h8000_000f);
        idx = used[0];
        mtc0(`CP0_INDEX, {28'd0, ~idx});
        mtc0(`CP0_ENTRYHI, {sh_hi[idx][31:13], 5'd0, ~cur_asid});
        tlb_op(OP_TLBP);
        mfc0("tlbp_global", `CP0_INDEX, {28'd0, idx}, 32'h8000_000f);

        // Back-to-back translation
        mtc0(`CP0_ENTRYHI, {24'd0, cur_asid});
        foreach (used[k]) begin
            r = $random(seed);
            translate({sh_hi[used[k]][31:13], 1'b0, r[11:0]});
            translate({sh_hi[used[k]][31:13], 1'b1, r[23:12]});
        end
        translate({14'h3fff, 1'b0, 4'hf, 1'b1, 12'habc});
        xreq = '0;
        xchk = 1'b0;
        idle(3);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* mips_cp0_tlb.f */
+incdir+.
cp0_pkg.sv
cp0_regs.sv
tlb_array.sv
cp0_tlb_top.sv
tb_cp0_tlb.sv

/* Makefile */
SIM := obj_dir/Vtb_cp0_tlb

all: run

$(SIM): mips_cp0_tlb.f cp0_params.svh cp0_pkg.sv cp0_regs.sv tlb_array.sv cp0_tlb_top.sv tb_cp0_tlb.sv
	verilator --binary --assert --timing --top-module tb_cp0_tlb -f mips_cp0_tlb.f

run: $(SIM)
	-./$(SIM) | tee sim.log
	@if grep -q "CHECKS FAILED" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
